// ==== hw/command_decoder.sv ====
`include "waves_consts.svh"

module command_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  byte              rx_byte,
    input  logic             rx_valid,
    output waves_pkg::wave_e wave_sel,
    output logic             noise_en,
    output waves_pkg::note_t note
);

    import waves_pkg::*;

    cmd_e cmd_class;

    // Letters take priority over the note interpretation
    always_comb begin
        case (rx_byte)
            `CMD_NOISE_ON:  cmd_class = cmd_noise_on;
            `CMD_NOISE_OFF: cmd_class = cmd_noise_off;
            `CMD_TRI:       cmd_class = cmd_tri;
            `CMD_SAW:       cmd_class = cmd_saw;
            `CMD_SQR:       cmd_class = cmd_sqr;
            default:        cmd_class = cmd_note;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wave_sel <= wave_off;
            noise_en <= 1'b0;
            note     <= '0;
        end else if (rx_valid) begin
            unique case (cmd_class)
                cmd_noise_on:  noise_en <= 1'b1;
                cmd_noise_off: noise_en <= 1'b0;
                cmd_tri:       wave_sel <= wave_tri;
                cmd_saw:       wave_sel <= wave_saw;
                cmd_sqr:       wave_sel <= wave_sqr;
                cmd_note: begin
                    if (rx_byte[`NOTE_W-1:0] < `NUM_NOTES) begin   // 60..63 ignored
                        note <= rx_byte[`NOTE_W-1:0];
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/i2s_transmitter.sv ====
`include "waves_consts.svh"

module i2s_transmitter (
    input  logic               clk,
    input  logic               rst_n,
    input  waves_pkg::sample_t sample,
    output logic               sck,
    output logic               ws,
    output logic               sd,
    output logic               frame_start
);

    localparam int WORD_W = 2 * `SAMPLE_W;

    logic [5:0]        frame_cnt;   // 64 clk per stereo frame
    logic [WORD_W-1:0] word_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt   <= '0;
            frame_start <= 1'b0;
            word_sr     <= '0;
            sd          <= 1'b0;
        end else begin
            frame_cnt   <= frame_cnt + 1'b1;
            frame_start <= (frame_cnt == 6'd63);   // High where ws has fallen
            if (frame_start) begin
                word_sr <= {sample, sample};
            end else if (frame_cnt[0]) begin
                // Next bit goes out on the falling sck edge
                sd      <= word_sr[WORD_W-1];
                word_sr <= {word_sr[WORD_W-2:0], word_sr[WORD_W-1]};
            end
        end
    end

    // Rotation leaves the word intact for the right channel
    assign sck = frame_cnt[0];
    assign ws  = frame_cnt[5];   // Low for left word

    a_frame_on_ws_fall: assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> (!ws && $past(ws)));

endmodule

// ==== hw/noise_lfsr.sv ====
`include "waves_consts.svh"

module noise_lfsr (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_start,
    output waves_pkg::sample_t noise_byte
);

    logic [15:0] lfsr;
    logic        feedback;

    // x^16 + x^14 + x^13 + x^11 + 1
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= `LFSR_SEED;
        end else if (frame_start) begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    assign noise_byte = lfsr[15:8];

    a_lfsr_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        lfsr != '0);

endmodule

// ==== hw/pitch_table.sv ====
`include "waves_consts.svh"

module pitch_table (
    input  waves_pkg::note_t  note,
    output waves_pkg::phase_t phase_inc
);

    import waves_pkg::*;

    logic [3:0] semitone;
    logic [2:0] octave;
    phase_t     base_inc;

    assign semitone = 4'(note % 6'd12);
    assign octave   = 3'(note / 6'd12);

    // Lowest octave ROM
    always_comb begin
        case (semitone)
            4'd0:    base_inc = `NOTE_INC_0;
            4'd1:    base_inc = `NOTE_INC_1;
            4'd2:    base_inc = `NOTE_INC_2;
            4'd3:    base_inc = `NOTE_INC_3;
            4'd4:    base_inc = `NOTE_INC_4;
            4'd5:    base_inc = `NOTE_INC_5;
            4'd6:    base_inc = `NOTE_INC_6;
            4'd7:    base_inc = `NOTE_INC_7;
            4'd8:    base_inc = `NOTE_INC_8;
            4'd9:    base_inc = `NOTE_INC_9;
            4'd10:   base_inc = `NOTE_INC_10;
            4'd11:   base_inc = `NOTE_INC_11;
            default: base_inc = `NOTE_INC_0;   // Unreachable remainder
        endcase
    end

    assign phase_inc = base_inc << octave;   // Each octave doubles the rate

endmodule

// ==== hw/tone_oscillator.sv ====
`include "waves_consts.svh"

module tone_oscillator (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_start,
    input  waves_pkg::wave_e   wave_sel,
    input  logic               noise_en,
    input  waves_pkg::phase_t  phase_inc,
    input  waves_pkg::sample_t noise_byte,
    output waves_pkg::sample_t sample
);

    import waves_pkg::*;

    phase_t  phase;
    sample_t shaped;
    logic    step_d;       // Frame step seen one cycle ago
    logic    top_bit;

    assign top_bit = phase[`PHASE_W-1];

    always_comb begin
        if (noise_en) begin
            shaped = noise_byte;   // Noise wins over any waveform
        end else begin
            unique case (wave_sel)
                wave_off: shaped = '0;
                wave_saw: shaped = phase[`PHASE_W-1 -: `SAMPLE_W];
                wave_sqr: shaped = {`SAMPLE_W{top_bit}};
                wave_tri: begin
                    if (top_bit) begin
                        shaped = ~phase[`PHASE_W-2 -: `SAMPLE_W];   // Falling half
                    end else begin
                        shaped = phase[`PHASE_W-2 -: `SAMPLE_W];
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= '0;
            step_d <= 1'b0;
            sample <= '0;
        end else begin
            step_d <= frame_start;
            if (frame_start) begin
                phase <= phase + phase_inc;
            end
            if (step_d) begin
                sample <= shaped;   // Phase and LFSR have settled
            end
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
`include "waves_consts.svh"

module uart_rx (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output byte  rx_byte,
    output logic rx_valid
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } state_e;

    state_e           state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;      // Line idles high
            rx_sync  <= 1'b1;
            state    <= idle;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state)
                idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= start;
                    end
                end
                start: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? idle : data;   // Glitch goes back to idle
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                data: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                stop: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt  <= '0;
                        rx_valid <= rx_sync;   // Framing error gives no strobe
                        state    <= idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == data && clk_cnt == FULL_BIT) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};   // LSB arrives first
        end
        if (state == stop && clk_cnt == FULL_BIT && rx_sync) begin
            rx_byte <= shift_reg;
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

// ==== hw/waves_consts.svh ====
`ifndef WAVES_CONSTS_SVH
`define WAVES_CONSTS_SVH

`define UART_CLKS_PER_BIT 16    // clk cycles per UART bit

`define SAMPLE_W 8
`define PHASE_W 16
`define NOTE_W 6
`define NUM_NOTES 60            // 5 octaves of 12 semitones

`define CMD_NOISE_ON 8'h4E      // 'N'
`define CMD_NOISE_OFF 8'h46     // 'F'
`define CMD_TRI 8'h54           // 'T'
`define CMD_SAW 8'h53           // 'S'
`define CMD_SQR 8'h51           // 'Q'

// Phase increments of the lowest octave, C up to B
`define NOTE_INC_0 16'd17
`define NOTE_INC_1 16'd18
`define NOTE_INC_2 16'd19
`define NOTE_INC_3 16'd20
`define NOTE_INC_4 16'd21
`define NOTE_INC_5 16'd23
`define NOTE_INC_6 16'd24
`define NOTE_INC_7 16'd25
`define NOTE_INC_8 16'd27
`define NOTE_INC_9 16'd29
`define NOTE_INC_10 16'd30
`define NOTE_INC_11 16'd32

`define LFSR_SEED 16'hACE1

`endif

// ==== hw/waves_pkg.sv ====
`include "waves_consts.svh"

package waves_pkg;

    typedef logic [`SAMPLE_W-1:0] sample_t;
    typedef logic [`PHASE_W-1:0] phase_t;
    typedef logic [`NOTE_W-1:0] note_t;

    // Waveform selected by the command letters
    typedef enum logic [1:0] {
        wave_off,
        wave_tri,
        wave_saw,
        wave_sqr
    } wave_e;

    // Class of a received byte
    typedef enum logic [2:0] {
        cmd_noise_on,
        cmd_noise_off,
        cmd_tri,
        cmd_saw,
        cmd_sqr,
        cmd_note       // Any byte that is not a command letter
    } cmd_e;

endpackage

// ==== hw/waves_top.sv ====
module waves_top (
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rx_line,
    output logic sck,
    output logic ws,
    output logic sd
);

    import waves_pkg::*;

    byte     rx_byte;
    logic    rx_valid;
    wave_e   wave_sel;
    logic    noise_en;
    note_t   note;
    phase_t  phase_inc;
    logic    frame_start;
    sample_t noise_byte;
    sample_t sample;

    uart_rx i_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (uart_rx_line),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    command_decoder i_command_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .wave_sel (wave_sel),
        .noise_en (noise_en),
        .note     (note)
    );

    pitch_table i_pitch_table (
        .note      (note),
        .phase_inc (phase_inc)
    );

    noise_lfsr i_noise_lfsr (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .noise_byte  (noise_byte)
    );

    tone_oscillator i_tone_oscillator (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .wave_sel    (wave_sel),
        .noise_en    (noise_en),
        .phase_inc   (phase_inc),
        .noise_byte  (noise_byte),
        .sample      (sample)
    );

    i2s_transmitter i_i2s_transmitter (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample      (sample),
        .sck         (sck),
        .ws          (ws),
        .sd          (sd),
        .frame_start (frame_start)
    );

endmodule

// ==== project.f ====
+incdir+hw
hw/waves_pkg.sv
hw/uart_rx.sv
hw/command_decoder.sv
hw/pitch_table.sv
hw/noise_lfsr.sv
hw/tone_oscillator.sv
hw/i2s_transmitter.sv
hw/waves_top.sv
sim/tb_clock_gen.sv
sim/waves_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
verilator --binary --timing -Wno-fatal -f project.f --top-module waves_tb \
    -o waves_sim > build.log 2>&1 \
    && ./obj_dir/waves_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // Period 20
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== sim/waves_tb.sv ====
`include "waves_consts.svh"

module waves_tb;

    localparam int NUM_TESTS = 10;
    localparam int K_ZERO = 0;
    localparam int K_SAW = 1;
    localparam int K_SQR = 2;
    localparam int K_TRI = 3;
    localparam int K_NOISE = 4;
    localparam int FRAME_CLKS = 64;        // Two words of 16 sck periods
    localparam int WORD_CLKS = 32;
    localparam int LEFT_DONE_CLKS = 17;    // Ninth sck rise of the left word

    logic clk, rst_n, uart_rx_line, sck, ws, sd;
    string names [NUM_TESTS];
    logic [7:0] cmd_a [NUM_TESTS];
    logic [7:0] cmd_b [NUM_TESTS];
    int n_bytes [NUM_TESTS];
    bit corrupt [NUM_TESTS];
    int kind [NUM_TESTS];
    int exp_note [NUM_TESTS];
    logic [7:0] left [8];
    logic [7:0] right [8];
    int ws_fall [8];
    int ws_rise [8];
    int left_done [8];
    int cycle_cnt;
    bit timed_out;
    int ok_count, bad_count;

    tb_clock_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    waves_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .uart_rx_line (uart_rx_line),
        .sck          (sck),
        .ws           (ws),
        .sd           (sd)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;   // Time base for I2S framing
    end

    // Base increment scaled by the octave
    function automatic int inc_for_note(input int n);
        int base;
        case (n % 12)
            0: base = `NOTE_INC_0;
            1: base = `NOTE_INC_1;
            2: base = `NOTE_INC_2;
            3: base = `NOTE_INC_3;
            4: base = `NOTE_INC_4;
            5: base = `NOTE_INC_5;
            6: base = `NOTE_INC_6;
            7: base = `NOTE_INC_7;
            8: base = `NOTE_INC_8;
            9: base = `NOTE_INC_9;
            10: base = `NOTE_INC_10;
            default: base = `NOTE_INC_11;
        endcase
        return base << (n / 12);
    endfunction

    task automatic set_row(input int i, input string nm, input int nb, input logic [7:0] a,
                           input logic [7:0] b, input bit bad_stop, input int k, input int nt);
        names[i] = nm;
        n_bytes[i] = nb;
        cmd_a[i] = a;
        cmd_b[i] = b;
        corrupt[i] = bad_stop;
        kind[i] = k;
        exp_note[i] = nt;
    endtask

    task automatic build_table();
        int r1;
        int r2;
        r1 = int'($urandom % 60);
        r2 = int'($urandom % 60);
        set_row(0, "reset_idle", 0, 8'h00, 8'h00, 0, K_ZERO, 0);
        set_row(1, "saw_rand_note", 2, `CMD_SAW, 8'(r1), 0, K_SAW, r1);
        set_row(2, "saw_rand_note2", 1, 8'(r2), 8'h00, 0, K_SAW, r2);
        set_row(3, "square", 1, `CMD_SQR, 8'h00, 0, K_SQR, r2);
        set_row(4, "tri_low", 2, `CMD_TRI, 8'd5, 0, K_TRI, 5);
        set_row(5, "noise_on", 1, `CMD_NOISE_ON, 8'h00, 0, K_NOISE, 5);
        set_row(6, "noise_off", 1, `CMD_NOISE_OFF, 8'h00, 0, K_TRI, 5);
        set_row(7, "saw_note_55", 2, `CMD_SAW, 8'd55, 0, K_SAW, 55);
        set_row(8, "bad_stop_bit", 1, 8'd0, 8'h00, 1, K_SAW, 55);
        set_row(9, "note_62", 1, 8'd62, 8'h00, 0, K_SAW, 55);
    endtask

    // 8N1 frame driven on falling edges
    task automatic send_byte(input logic [7:0] b, input bit bad_stop);
        logic [9:0] bits;
        bits = {~bad_stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx_line = bits[i];
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
        end
        uart_rx_line = 1'b1;
        repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic wait_ws(input logic level);
        logic prev;
        bit found;
        prev = ws;
        found = 0;
        for (int n = 0; n < 200 && !found; n++) begin
            @(negedge clk);
            if (prev != level && ws == level) found = 1;
            prev = ws;
        end
        if (!found) begin
            $display("timeout: word select never toggled");
            timed_out = 1;
        end
    endtask

    // Skip the delay bit after ws changes and shift in MSB first
    task automatic read_word(output logic [7:0] val);
        logic prev;
        int rises;
        prev = sck;
        rises = 0;
        val = '0;
        for (int n = 0; n < 100 && rises < 9; n++) begin
            @(negedge clk);
            if (!prev && sck) begin
                if (rises > 0) val = {val[6:0], sd};
                rises++;
            end
            prev = sck;
        end
        if (rises < 9) begin
            $display("timeout: bit clock stopped during a word");
            timed_out = 1;
        end
    endtask

    initial begin
        int diff, e, limit;
        bit bad, all_same;
        int bexp, bact;
        uart_rx_line = 1'b1;
        timed_out = 0;
        ok_count = 0;
        bad_count = 0;
        void'($urandom(32'h432c_63ae));
        build_table();
        for (int n = 0; n < 100 && rst_n !== 1'b1; n++) begin
            @(negedge clk);
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1;
        end
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            if (n_bytes[t] > 0) send_byte(cmd_a[t], corrupt[t]);
            if (n_bytes[t] > 1) send_byte(cmd_b[t], 0);
            for (int f = 0; f < 3 && !timed_out; f++) wait_ws(1'b0);
            for (int f = 0; f < 8 && !timed_out; f++) begin
                wait_ws(1'b0);
                ws_fall[f] = cycle_cnt;
                if (!timed_out) read_word(left[f]);
                left_done[f] = cycle_cnt;
                if (!timed_out) wait_ws(1'b1);
                ws_rise[f] = cycle_cnt;
                if (!timed_out) read_word(right[f]);
            end
            if (timed_out) begin
                $display("%s: no complete I2S capture", names[t]);
                bad_count++;
                break;
            end
            bad = 0;
            bexp = 0;
            bact = 0;
            e = inc_for_note(exp_note[t]);
            all_same = 1;
            for (int i = 0; i < 8; i++) begin
                if (left[i] != right[i] && !bad) begin
                    bad = 1;
                    bexp = int'(left[i]);
                    bact = int'(right[i]);
                end
                if (i > 0 && ws_fall[i] - ws_fall[i - 1] != FRAME_CLKS && !bad) begin
                    bad = 1;
                    bexp = FRAME_CLKS;
                    bact = ws_fall[i] - ws_fall[i - 1];
                end
                if (ws_rise[i] - ws_fall[i] != WORD_CLKS && !bad) begin
                    bad = 1;
                    bexp = WORD_CLKS;
                    bact = ws_rise[i] - ws_fall[i];
                end
                if (left_done[i] - ws_fall[i] != LEFT_DONE_CLKS && !bad) begin
                    bad = 1;
                    bexp = LEFT_DONE_CLKS;
                    bact = left_done[i] - ws_fall[i];
                end
                if (i > 0 && left[i] != left[0]) all_same = 0;
                if (kind[t] == K_ZERO && left[i] != 8'd0 && !bad) begin
                    bad = 1;
                    bexp = 0;
                    bact = int'(left[i]);
                end
                if (kind[t] == K_SQR && left[i] != 8'd0 && left[i] != 8'd255 && !bad) begin
                    bad = 1;
                    bexp = 255;
                    bact = int'(left[i]);
                end
                if (i < 7 && kind[t] == K_SAW) begin
                    diff = (int'(left[i + 1]) - int'(left[i])) & 255;
                    if (diff != (e >> 8) && diff != (((e >> 8) + 1) & 255) && !bad) begin
                        bad = 1;
                        bexp = e >> 8;
                        bact = diff;
                    end
                end
                if (i < 7 && kind[t] == K_TRI) begin
                    diff = int'(left[i + 1]) - int'(left[i]);
                    if (diff < 0) diff = -diff;
                    limit = (e >> 7) + 1;
                    if (diff > limit && !bad) begin
                        bad = 1;
                        bexp = limit;
                        bact = diff;
                    end
                end
                if (i < 7 && kind[t] == K_NOISE) begin
                    if (left[i + 1][7:1] != left[i][6:0] && !bad) begin
                        bad = 1;
                        bexp = int'(left[i][6:0]);
                        bact = int'(left[i + 1][7:1]);
                    end
                end
            end
            if (kind[t] == K_NOISE && all_same && !bad) begin
                $display("%s: noise samples never change", names[t]);
                bad_count++;
            end else if (bad) begin
                $display("mismatch %s: expected %0d, actual %0d", names[t], bexp, bact);
                bad_count++;
            end else begin
                $display("%s: ok", names[t]);
                ok_count++;
            end
        end
        $display("tests ok: %0d, tests bad: %0d", ok_count, bad_count);
        if (bad_count == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
